//--- Makefile
compile:
	verilator --binary --timing --assert -f verilog.f --top-module tb_d1_miss_subsys \
	  -Mdir obj_dir -o sim_tb

run: compile
	./obj_dir/sim_tb > sim.log 2>&1; cat sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: compile run clean

//--- d1_L2_req_arbiter.sv
// Purely combinational; a refill is masked whenever its pending count exceeds the free WBB slots
module d1_L2_req_arbiter (
  // Requests from both sources
  input  logic                          mshr_l2c_req_valid_i,
  input  logic                          wbb_l2c_req_valid_i,
  // L2 channel can take a request
  input  logic                          l2c_l1dc_req_rdy_i,
  // Counts for the tie rule
  input  d1_mem_pkg::mshr_pending_req_t mshr_pending_req_i,
  input  d1_mem_pkg::wbb_free_entries_t wbb_free_entries_i,
  // WBB busy forwarding to a load this cycle
  input  logic                          wbb_d0_fwd_i,
  // Granted source
  output d1_mem_pkg::mshr_wbb_winner_e  winner_o,
  // Per-source accept
  output logic                          mshr_l2c_transaction_ok_o,
  output logic                          wbb_l2c_transaction_ok_o,
  // Some request is being offered
  output logic                          d1_l2c_valid_o
);

  import d1_mem_pkg::*;

  // Every refill still has room for the eviction it may cause
  logic mshr_fits;

  assign mshr_fits = (mshr_pending_req_i <= wbb_free_entries_i);

  always_comb begin
    winner_o       = MSHR;
    d1_l2c_valid_o = 1'b0;
    // WBB alone, or tie once the MSHR no longer fits
    if (wbb_l2c_req_valid_i && (!mshr_l2c_req_valid_i || !mshr_fits)) begin
      winner_o       = WBB;
      // Held back while the buffer forwards
      d1_l2c_valid_o = !wbb_d0_fwd_i;
    // MSHR alone or tie while it fits
    end else if (mshr_l2c_req_valid_i && mshr_fits) begin
      winner_o       = MSHR;
      d1_l2c_valid_o = 1'b1;
    end
    // MSHR alone without room stays masked
  end

  assign mshr_l2c_transaction_ok_o = l2c_l1dc_req_rdy_i && d1_l2c_valid_o && (winner_o == MSHR);
  assign wbb_l2c_transaction_ok_o  = l2c_l1dc_req_rdy_i && d1_l2c_valid_o && (winner_o == WBB);

  // At most one source pops per cycle
  always_comb begin
    a_one_ok: assert final (!(mshr_l2c_transaction_ok_o && wbb_l2c_transaction_ok_o));
  end

endmodule

//--- d1_defs.svh
// Both queue depths must be powers of two; counts are sized from them in d1_mem_pkg
`ifndef D1_DEFS_SVH
`define D1_DEFS_SVH

// Physical address width
// Split into tag, set and offset in d1_l2_pkg
`define D1_ADDR_W 32

// Data word carried with each eviction
// Zero on the L2 port for refills
`define D1_DATA_W 32

// Refill requests held before misses must stall
`define D1_MSHR_DEPTH 4

// Dirty lines held before evictions must stall
// Also bounds how many refills may be in flight at once
`define D1_WBB_DEPTH 4

`endif

//--- d1_l2_pkg.sv
// Address split assumes 16-byte lines and 256 sets; the tag takes all remaining upper bits
`include "d1_defs.svh"

package d1_l2_pkg;

  // Field widths of one address word
  localparam int unsigned L2_OFF_W = 4;
  localparam int unsigned L2_SET_W = 8;
  localparam int unsigned L2_TAG_W = `D1_ADDR_W - L2_SET_W - L2_OFF_W;

  // Command on the L2 request port
  typedef enum logic {
    READ_LINE  = 1'b0,
    WRITE_LINE = 1'b1
  } l2_cmd_e;

  // One address word, seen raw or as cache fields
  typedef union packed {
    logic [`D1_ADDR_W-1:0] raw;
    struct packed {
      logic [L2_TAG_W-1:0] tag;
      logic [L2_SET_W-1:0] set;
      logic [L2_OFF_W-1:0] offset;
    } fields;
  } l2_addr_u;

endpackage

//--- d1_l2_req_issue.sv
// Output payload is meaningful only while l2_req_valid_o is high; no stall on the L2 side after issue
`include "d1_defs.svh"

module d1_l2_req_issue (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // MSHR head
  input  logic                          mshr_req_valid_i,
  input  d1_l2_pkg::l2_addr_u           mshr_req_addr_i,
  input  d1_mem_pkg::mshr_pending_req_t mshr_pending_i,
  // WBB head
  input  logic                          wbb_req_valid_i,
  input  d1_l2_pkg::l2_addr_u           wbb_req_addr_i,
  input  logic [`D1_DATA_W-1:0]         wbb_req_data_i,
  input  d1_mem_pkg::wbb_free_entries_t wbb_free_i,
  input  logic                          wbb_fwd_i,
  // L2 ready level
  input  logic                          l2_req_rdy_i,
  // Pop strobes back to the sources
  output logic                          mshr_ok_o,
  output logic                          wbb_ok_o,
  // Registered L2 request
  output logic                          l2_req_valid_o,
  output d1_l2_pkg::l2_cmd_e            l2_req_cmd_o,
  output d1_l2_pkg::l2_addr_u           l2_req_addr_o,
  output logic [`D1_DATA_W-1:0]         l2_req_data_o
);

  import d1_mem_pkg::*;
  import d1_l2_pkg::*;

  mshr_wbb_winner_e      winner;
  logic                  any_valid;
  logic                  load;
  l2_cmd_e               sel_cmd;
  l2_addr_u              sel_addr;
  logic [`D1_DATA_W-1:0] sel_data;

  d1_L2_req_arbiter u_arbiter (
    .mshr_l2c_req_valid_i      (mshr_req_valid_i),
    .wbb_l2c_req_valid_i       (wbb_req_valid_i),
    .l2c_l1dc_req_rdy_i        (l2_req_rdy_i),
    .mshr_pending_req_i        (mshr_pending_i),
    .wbb_free_entries_i        (wbb_free_i),
    .wbb_d0_fwd_i              (wbb_fwd_i),
    .winner_o                  (winner),
    .mshr_l2c_transaction_ok_o (mshr_ok_o),
    .wbb_l2c_transaction_ok_o  (wbb_ok_o),
    .d1_l2c_valid_o            (any_valid)
  );

  // Same condition as either ok
  assign load = any_valid && l2_req_rdy_i;

  // Refills carry no data
  always_comb begin
    if (winner == WBB) begin
      sel_cmd  = WRITE_LINE;
      sel_addr = wbb_req_addr_i;
      sel_data = wbb_req_data_i;
    end else begin
      sel_cmd  = READ_LINE;
      sel_addr = mshr_req_addr_i;
      sel_data = '0;
    end
  end

  // Valid pulse, one cycle per accepted request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      l2_req_valid_o <= 1'b0;
    end else begin
      l2_req_valid_o <= load;
    end
  end

  // Payload held until the next accept
  always_ff @(posedge clk_i) begin
    if (load) begin
      l2_req_cmd_o  <= sel_cmd;
      l2_req_addr_o <= sel_addr;
      l2_req_data_o <= sel_data;
    end
  end

  // Back-to-back pulses need a fresh ok from a source
  a_pulse_per_ok: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (l2_req_valid_o && !(mshr_ok_o || wbb_ok_o)) |=> !l2_req_valid_o);

endmodule

//--- d1_mem_pkg.sv
// Count widths follow the depths in d1_defs.svh and must cover 0 up to the full depth
`include "d1_defs.svh"

package d1_mem_pkg;

  // Source that owns the L2 request channel this cycle
  // MSHR is also the idle value
  typedef enum logic {
    MSHR = 1'b0,
    WBB  = 1'b1
  } mshr_wbb_winner_e;

  // Refills waiting to be sent
  // 0 means the MSHR is empty
  typedef logic [$clog2(`D1_MSHR_DEPTH+1)-1:0] mshr_pending_req_t;

  // Empty write-back slots
  // Compared against the MSHR count on a tie
  typedef logic [$clog2(`D1_WBB_DEPTH+1)-1:0] wbb_free_entries_t;

endpackage

//--- d1_miss_subsys.sv
// Environment must not push into a full MSHR or WBB; L2 responses and refill data are not modelled
`include "d1_defs.svh"

module d1_miss_subsys (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Cache misses
  input  logic                  miss_valid_i,
  input  d1_l2_pkg::l2_addr_u   miss_addr_i,
  // Dirty evictions
  input  logic                  evict_valid_i,
  input  d1_l2_pkg::l2_addr_u   evict_addr_i,
  input  logic [`D1_DATA_W-1:0] evict_data_i,
  // Load lookup into the WBB
  input  logic                  ld_lookup_i,
  input  d1_l2_pkg::l2_addr_u   ld_addr_i,
  output logic                  fwd_hit_o,
  output logic [`D1_DATA_W-1:0] fwd_data_o,
  // L2 request port
  input  logic                  l2_req_rdy_i,
  output logic                  l2_req_valid_o,
  output d1_l2_pkg::l2_cmd_e    l2_req_cmd_o,
  output d1_l2_pkg::l2_addr_u   l2_req_addr_o,
  output logic [`D1_DATA_W-1:0] l2_req_data_o
);

  import d1_mem_pkg::*;
  import d1_l2_pkg::*;

  // MSHR head and count
  logic                  mshr_req_valid;
  l2_addr_u              mshr_req_addr;
  mshr_pending_req_t     mshr_pending;
  // WBB head, count and forward flag
  logic                  wbb_req_valid;
  l2_addr_u              wbb_req_addr;
  logic [`D1_DATA_W-1:0] wbb_req_data;
  wbb_free_entries_t     wbb_free;
  logic                  wbb_d0_fwd;
  // Pop strobes
  logic                  mshr_ok;
  logic                  wbb_ok;

  // Forward flag goes out and also stalls the WBB request
  assign fwd_hit_o = wbb_d0_fwd;

  d1_mshr_queue u_mshr_queue (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .miss_valid_i (miss_valid_i),
    .miss_addr_i  (miss_addr_i),
    .req_ok_i     (mshr_ok),
    .req_valid_o  (mshr_req_valid),
    .req_addr_o   (mshr_req_addr),
    .pending_o    (mshr_pending)
  );

  d1_wb_buffer u_wb_buffer (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .evict_valid_i (evict_valid_i),
    .evict_addr_i  (evict_addr_i),
    .evict_data_i  (evict_data_i),
    .req_ok_i      (wbb_ok),
    .ld_lookup_i   (ld_lookup_i),
    .ld_addr_i     (ld_addr_i),
    .req_valid_o   (wbb_req_valid),
    .req_addr_o    (wbb_req_addr),
    .req_data_o    (wbb_req_data),
    .free_o        (wbb_free),
    .fwd_hit_o     (wbb_d0_fwd),
    .fwd_data_o    (fwd_data_o)
  );

  d1_l2_req_issue u_l2_req_issue (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .mshr_req_valid_i (mshr_req_valid),
    .mshr_req_addr_i  (mshr_req_addr),
    .mshr_pending_i   (mshr_pending),
    .wbb_req_valid_i  (wbb_req_valid),
    .wbb_req_addr_i   (wbb_req_addr),
    .wbb_req_data_i   (wbb_req_data),
    .wbb_free_i       (wbb_free),
    .wbb_fwd_i        (wbb_d0_fwd),
    .l2_req_rdy_i     (l2_req_rdy_i),
    .mshr_ok_o        (mshr_ok),
    .wbb_ok_o         (wbb_ok),
    .l2_req_valid_o   (l2_req_valid_o),
    .l2_req_cmd_o     (l2_req_cmd_o),
    .l2_req_addr_o    (l2_req_addr_o),
    .l2_req_data_o    (l2_req_data_o)
  );

endmodule

//--- d1_mshr_queue.sv
// Power-of-two depth only; a miss may enter a full queue only in the cycle its oldest entry leaves
`include "d1_defs.svh"

module d1_mshr_queue (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // New refill from a cache miss
  input  logic                          miss_valid_i,
  input  d1_l2_pkg::l2_addr_u           miss_addr_i,
  // Oldest entry taken by the L2 port
  input  logic                          req_ok_i,
  // Oldest entry toward the issue stage
  output logic                          req_valid_o,
  output d1_l2_pkg::l2_addr_u           req_addr_o,
  // Occupancy for the arbiter tie rule
  output d1_mem_pkg::mshr_pending_req_t pending_o
);

  import d1_mem_pkg::*;
  import d1_l2_pkg::*;

  localparam int unsigned PTR_W = $clog2(`D1_MSHR_DEPTH);

  // Refill line addresses
  l2_addr_u          addr_mem [`D1_MSHR_DEPTH];
  // Read side, oldest entry
  logic [PTR_W-1:0]  head_q;
  // Write side, next free slot
  logic [PTR_W-1:0]  tail_q;
  mshr_pending_req_t count_q;
  logic              full;

  assign full = (count_q == mshr_pending_req_t'(`D1_MSHR_DEPTH));

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (miss_valid_i) begin
        tail_q <= tail_q + 1'b1;
      end
      if (req_ok_i) begin
        head_q <= head_q + 1'b1;
      end
      // Push and pop together keep the count
      case ({miss_valid_i, req_ok_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Address storage
  always_ff @(posedge clk_i) begin
    if (miss_valid_i) begin
      addr_mem[tail_q] <= miss_addr_i;
    end
  end

  // Request stays up while anything is queued
  assign req_valid_o = (count_q != '0);
  assign req_addr_o  = addr_mem[head_q];
  assign pending_o   = count_q;

  // Full queue takes a miss only while the issue stage drains it
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (miss_valid_i && full) |-> req_ok_i);

endmodule

//--- d1_wb_buffer.sv
// Power-of-two depth only; forwarding matches tag and set and ignores the line offset
`include "d1_defs.svh"

module d1_wb_buffer (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Dirty line evicted from the cache
  input  logic                          evict_valid_i,
  input  d1_l2_pkg::l2_addr_u           evict_addr_i,
  input  logic [`D1_DATA_W-1:0]         evict_data_i,
  // Oldest entry taken by the L2 port
  input  logic                          req_ok_i,
  // Load lookup against buffered lines
  input  logic                          ld_lookup_i,
  input  d1_l2_pkg::l2_addr_u           ld_addr_i,
  // Oldest entry toward the issue stage
  output logic                          req_valid_o,
  output d1_l2_pkg::l2_addr_u           req_addr_o,
  output logic [`D1_DATA_W-1:0]         req_data_o,
  // Empty slots for the arbiter tie rule
  output d1_mem_pkg::wbb_free_entries_t free_o,
  // Same-cycle forward result
  output logic                          fwd_hit_o,
  output logic [`D1_DATA_W-1:0]         fwd_data_o
);

  import d1_mem_pkg::*;
  import d1_l2_pkg::*;

  localparam int unsigned PTR_W = $clog2(`D1_WBB_DEPTH);

  // Evicted line addresses and data
  l2_addr_u                 addr_mem [`D1_WBB_DEPTH];
  logic [`D1_DATA_W-1:0]    data_mem [`D1_WBB_DEPTH];
  // One valid bit per slot
  logic [`D1_WBB_DEPTH-1:0] valid_q;
  logic [PTR_W-1:0]         head_q;
  logic [PTR_W-1:0]         tail_q;
  wbb_free_entries_t        count_q;
  logic                     hit;
  logic [`D1_DATA_W-1:0]    hit_data;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      // Clear before set, so a push into a slot freed this cycle wins
      if (req_ok_i) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_q + 1'b1;
      end
      if (evict_valid_i) begin
        valid_q[tail_q] <= 1'b1;
        tail_q          <= tail_q + 1'b1;
      end
      case ({evict_valid_i, req_ok_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Line storage
  always_ff @(posedge clk_i) begin
    if (evict_valid_i) begin
      addr_mem[tail_q] <= evict_addr_i;
      data_mem[tail_q] <= evict_data_i;
    end
  end

  // Walk oldest to newest so the newest match is left standing
  always_comb begin
    logic [PTR_W-1:0] idx;
    hit      = 1'b0;
    hit_data = '0;
    for (int unsigned i = 0; i < `D1_WBB_DEPTH; i++) begin
      idx = head_q + PTR_W'(i);
      if (valid_q[idx] && (addr_mem[idx].fields.tag == ld_addr_i.fields.tag) &&
          (addr_mem[idx].fields.set == ld_addr_i.fields.set)) begin
        hit      = 1'b1;
        hit_data = data_mem[idx];
      end
    end
  end

  assign fwd_hit_o  = ld_lookup_i && hit;
  assign fwd_data_o = ld_lookup_i ? hit_data : '0;

  // Head slot is the write-back candidate
  assign req_valid_o = valid_q[head_q];
  assign req_addr_o  = addr_mem[head_q];
  assign req_data_o  = data_mem[head_q];
  assign free_o      = wbb_free_entries_t'(`D1_WBB_DEPTH) - count_q;

  // Full buffer takes an eviction only while the issue stage drains it
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (evict_valid_i && (free_o == '0)) |-> req_ok_i);

endmodule

//--- tb_d1_miss_subsys.sv
// Directed tests against a queue model of MSHR and WBB; never pushes into a full source
`include "d1_defs.svh"

module tb_d1_miss_subsys;

  import d1_mem_pkg::*;
  import d1_l2_pkg::*;

  localparam int unsigned CLK_PERIOD   = 40;
  localparam int unsigned RESET_CYCLES = 16;
  // Rough length of each test in cycles summed for the watchdog
  localparam int unsigned TEST_CYCLES  = 20 + 50 + 40 + 40 + 30;
  localparam int unsigned WDOG_CYCLES  = RESET_CYCLES + TEST_CYCLES + 60;
  localparam int unsigned DRAIN_LIMIT  = 20;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  miss_valid_i;
  l2_addr_u              miss_addr_i;
  logic                  evict_valid_i;
  l2_addr_u              evict_addr_i;
  logic [`D1_DATA_W-1:0] evict_data_i;
  logic                  ld_lookup_i;
  l2_addr_u              ld_addr_i;
  logic                  fwd_hit_o;
  logic [`D1_DATA_W-1:0] fwd_data_o;
  logic                  l2_req_rdy_i;
  logic                  l2_req_valid_o;
  l2_cmd_e               l2_req_cmd_o;
  l2_addr_u              l2_req_addr_o;
  logic [`D1_DATA_W-1:0] l2_req_data_o;

  // Model of both queues with the oldest entry first
  l2_addr_u              mshr_q [$];
  l2_addr_u              wbb_addr_q [$];
  logic [`D1_DATA_W-1:0] wbb_data_q [$];
  // Commands seen on the L2 port in the running test
  l2_cmd_e               issued_cmds [$];
  int unsigned           mismatch_errs;
  int unsigned           other_errs;

  d1_miss_subsys u_d1_miss_subsys (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .miss_valid_i   (miss_valid_i),
    .miss_addr_i    (miss_addr_i),
    .evict_valid_i  (evict_valid_i),
    .evict_addr_i   (evict_addr_i),
    .evict_data_i   (evict_data_i),
    .ld_lookup_i    (ld_lookup_i),
    .ld_addr_i      (ld_addr_i),
    .fwd_hit_o      (fwd_hit_o),
    .fwd_data_o     (fwd_data_o),
    .l2_req_rdy_i   (l2_req_rdy_i),
    .l2_req_valid_o (l2_req_valid_o),
    .l2_req_cmd_o   (l2_req_cmd_o),
    .l2_req_addr_o  (l2_req_addr_o),
    .l2_req_data_o  (l2_req_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic check_cmd(input string name, input l2_cmd_e act, input l2_cmd_e exp);
    if (act !== exp) begin
      mismatch_errs++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, act, exp);
    end
  endtask

  task automatic check_addr(input string name, input l2_addr_u act, input l2_addr_u exp);
    if (act !== exp) begin
      mismatch_errs++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, act, exp);
    end
  endtask

  task automatic check_data(input string name, input logic [`D1_DATA_W-1:0] act,
                            input logic [`D1_DATA_W-1:0] exp);
    if (act !== exp) begin
      mismatch_errs++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, act, exp);
    end
  endtask

  task automatic check_hit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      mismatch_errs++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, act, exp);
    end
  endtask

  // Strobes and handshake levels
  task automatic check_valid(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      mismatch_errs++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, act, exp);
    end
  endtask

  task automatic expect_count(input string what, input int unsigned n);
    if (issued_cmds.size() != n) begin
      other_errs++;
      $display("%s: expected %0d requests on the L2 port but saw %0d", what, n,
               issued_cmds.size());
    end
  endtask

  // Newest buffered line with the same tag and set and any offset
  task automatic model_forward(output logic hit, output logic [`D1_DATA_W-1:0] data);
    hit  = 1'b0;
    data = '0;
    if (ld_lookup_i) begin
      foreach (wbb_addr_q[i]) begin
        if (wbb_addr_q[i].raw[`D1_ADDR_W-1:L2_OFF_W] == ld_addr_i.raw[`D1_ADDR_W-1:L2_OFF_W]) begin
          hit  = 1'b1;
          data = wbb_data_q[i];
        end
      end
    end
  endtask

  task automatic push_miss(input l2_addr_u addr);
    miss_valid_i = 1'b1;
    miss_addr_i  = addr;
  endtask

  task automatic push_evict(input l2_addr_u addr, input logic [`D1_DATA_W-1:0] data);
    evict_valid_i = 1'b1;
    evict_addr_i  = addr;
    evict_data_i  = data;
  endtask

  // Entered on a falling edge with inputs driven and returns on the next one
  task automatic run_cycle();
    logic                  hit;
    logic [`D1_DATA_W-1:0] hit_data;
    logic                  mshr_room;
    logic                  grant_mshr;
    logic                  grant_wbb;
    l2_cmd_e               exp_cmd;
    l2_addr_u              exp_addr;
    logic [`D1_DATA_W-1:0] exp_data;
    #1;
    model_forward(hit, hit_data);
    check_hit("fwd_hit_o", fwd_hit_o, hit);
    if (hit) begin
      check_data("fwd_data_o", fwd_data_o, hit_data);
    end
    // Refill first only if the WBB can absorb the eviction of every pending refill
    mshr_room  = (mshr_q.size() != 0) && (mshr_q.size() <= (`D1_WBB_DEPTH - wbb_addr_q.size()));
    grant_mshr = l2_req_rdy_i && mshr_room;
    // Otherwise the WBB unless a forward holds it back
    grant_wbb  = l2_req_rdy_i && !mshr_room && (wbb_addr_q.size() != 0) && !hit;
    check_valid("mshr_ok", u_d1_miss_subsys.mshr_ok, grant_mshr);
    check_valid("wbb_ok", u_d1_miss_subsys.wbb_ok, grant_wbb);
    exp_cmd  = READ_LINE;
    exp_addr = '0;
    exp_data = '0;
    if (grant_mshr) begin
      exp_addr = mshr_q.pop_front();
    end else if (grant_wbb) begin
      exp_cmd  = WRITE_LINE;
      exp_addr = wbb_addr_q.pop_front();
      exp_data = wbb_data_q.pop_front();
    end
    // Pushes land behind any pop of the same edge
    if (miss_valid_i) begin
      mshr_q.push_back(miss_addr_i);
    end
    if (evict_valid_i) begin
      wbb_addr_q.push_back(evict_addr_i);
      wbb_data_q.push_back(evict_data_i);
    end
    @(posedge clk_i);
    @(negedge clk_i);
    miss_valid_i  = 1'b0;
    evict_valid_i = 1'b0;
    // Pulse one edge after the ok
    check_valid("l2_req_valid_o", l2_req_valid_o, grant_mshr || grant_wbb);
    if (l2_req_valid_o) begin
      issued_cmds.push_back(l2_req_cmd_o);
    end
    if (grant_mshr || grant_wbb) begin
      check_cmd("l2_req_cmd_o", l2_req_cmd_o, exp_cmd);
      check_addr("l2_req_addr_o", l2_req_addr_o, exp_addr);
      check_data("l2_req_data_o", l2_req_data_o, exp_data);
    end
  endtask

  task automatic drain_queues();
    int unsigned n;
    n = 0;
    while (((mshr_q.size() != 0) || (wbb_addr_q.size() != 0)) && (n < DRAIN_LIMIT)) begin
      run_cycle();
      n++;
    end
    if ((mshr_q.size() != 0) || (wbb_addr_q.size() != 0)) begin
      other_errs++;
      $display("Queued requests were still waiting after %0d cycles", DRAIN_LIMIT);
    end
    // Idle cycle with no stray pulse
    run_cycle();
  endtask

  task automatic single_requests();
    issued_cmds.delete();
    l2_req_rdy_i = 1'b1;
    push_miss($urandom());
    run_cycle();
    drain_queues();
    expect_count("single miss", 1);
    check_cmd("l2_req_cmd_o of single miss", issued_cmds[0], READ_LINE);
    issued_cmds.delete();
    push_evict($urandom(), $urandom());
    run_cycle();
    drain_queues();
    expect_count("single eviction", 1);
    check_cmd("l2_req_cmd_o of single eviction", issued_cmds[0], WRITE_LINE);
  endtask

  task automatic tie_policy();
    issued_cmds.delete();
    l2_req_rdy_i = 1'b0;
    // Pending 2 and free 2
    repeat (2) begin
      push_miss($urandom());
      push_evict($urandom(), $urandom());
      run_cycle();
    end
    l2_req_rdy_i = 1'b1;
    drain_queues();
    expect_count("tie with room", 4);
    check_cmd("l2_req_cmd_o of first tie with room", issued_cmds[0], READ_LINE);
    check_cmd("l2_req_cmd_o of second tie with room", issued_cmds[1], READ_LINE);
    issued_cmds.delete();
    l2_req_rdy_i = 1'b0;
    // Pending 2 and free 1
    repeat (2) begin
      push_miss($urandom());
      push_evict($urandom(), $urandom());
      run_cycle();
    end
    push_evict($urandom(), $urandom());
    run_cycle();
    l2_req_rdy_i = 1'b1;
    drain_queues();
    expect_count("tie without room", 5);
    check_cmd("l2_req_cmd_o of first tie without room", issued_cmds[0], WRITE_LINE);
  endtask

  task automatic masked_refill();
    l2_addr_u first_line;
    l2_addr_u probe;
    issued_cmds.delete();
    l2_req_rdy_i = 1'b0;
    first_line   = $urandom();
    push_miss($urandom());
    push_evict(first_line, $urandom());
    run_cycle();
    repeat (3) begin
      push_evict($urandom(), $urandom());
      run_cycle();
    end
    // WBB full and held by a forward so the refill has no room
    probe               = first_line;
    probe.fields.offset = ~first_line.fields.offset;
    l2_req_rdy_i        = 1'b1;
    ld_lookup_i         = 1'b1;
    ld_addr_i           = probe;
    repeat (4) begin
      run_cycle();
    end
    expect_count("masked refill while WBB forwards", 0);
    ld_lookup_i = 1'b0;
    drain_queues();
    expect_count("masked refill after drain", 5);
    check_cmd("l2_req_cmd_o of first masked refill issue", issued_cmds[0], WRITE_LINE);
    check_cmd("l2_req_cmd_o of second masked refill issue", issued_cmds[1], READ_LINE);
  endtask

  task automatic backpressure_release();
    issued_cmds.delete();
    l2_req_rdy_i = 1'b0;
    repeat (2) begin
      push_miss($urandom());
      push_evict($urandom(), $urandom());
      run_cycle();
    end
    push_miss($urandom());
    run_cycle();
    repeat (6) begin
      run_cycle();
    end
    expect_count("held back by L2", 0);
    l2_req_rdy_i = 1'b1;
    drain_queues();
    expect_count("after L2 release", 5);
  endtask

  task automatic load_forward();
    l2_addr_u              line_a;
    l2_addr_u              line_a2;
    l2_addr_u              other_line;
    logic [`D1_DATA_W-1:0] newer_data;
    issued_cmds.delete();
    l2_req_rdy_i            = 1'b0;
    line_a                  = $urandom();
    line_a2                 = line_a;
    line_a2.fields.offset   = line_a.fields.offset + 1'b1;
    other_line              = line_a;
    other_line.fields.tag   = ~line_a.fields.tag;
    newer_data              = $urandom();
    push_evict(line_a, $urandom());
    run_cycle();
    push_evict(other_line, $urandom());
    run_cycle();
    push_evict(line_a2, newer_data);
    run_cycle();
    l2_req_rdy_i = 1'b1;
    ld_lookup_i  = 1'b1;
    ld_addr_i    = line_a;
    #1;
    check_hit("fwd_hit_o on buffered line", fwd_hit_o, 1'b1);
    check_data("fwd_data_o from newest entry", fwd_data_o, newer_data);
    run_cycle();
    expect_count("WBB issue during forward", 0);
    // Same tag as line A in another set matches nothing
    ld_addr_i            = line_a;
    ld_addr_i.fields.set = ~line_a.fields.set;
    #1;
    check_hit("fwd_hit_o on unbuffered line", fwd_hit_o, 1'b0);
    run_cycle();
    expect_count("WBB issue after forward", 1);
    ld_lookup_i = 1'b0;
    drain_queues();
    expect_count("forward test total", 3);
  endtask

  initial begin
    void'($urandom(62));
    mismatch_errs = 0;
    other_errs    = 0;
    rst_n_i       = 1'b0;
    miss_valid_i  = 1'b0;
    miss_addr_i   = '0;
    evict_valid_i = 1'b0;
    evict_addr_i  = '0;
    evict_data_i  = '0;
    ld_lookup_i   = 1'b0;
    ld_addr_i     = '0;
    l2_req_rdy_i  = 1'b0;
    repeat (RESET_CYCLES - 1) begin
      @(negedge clk_i);
    end
    // L2 ready and a lookup offered in the last reset cycle with both queues empty
    l2_req_rdy_i = 1'b1;
    ld_lookup_i  = 1'b1;
    @(negedge clk_i);
    check_valid("l2_req_valid_o after reset", l2_req_valid_o, 1'b0);
    check_hit("fwd_hit_o after reset", fwd_hit_o, 1'b0);
    check_valid("mshr_ok after reset", u_d1_miss_subsys.mshr_ok, 1'b0);
    check_valid("wbb_ok after reset", u_d1_miss_subsys.wbb_ok, 1'b0);
    ld_lookup_i = 1'b0;
    rst_n_i     = 1'b1;
    single_requests();
    tie_policy();
    masked_refill();
    backpressure_release();
    load_forward();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if ((mismatch_errs + other_errs) == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Ends a run whose tests stall
  initial begin
    repeat (WDOG_CYCLES) begin
      @(posedge clk_i);
    end
    other_errs++;
    $display("Timeout: the tests did not finish within %0d cycles", WDOG_CYCLES);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+.
d1_mem_pkg.sv
d1_l2_pkg.sv
d1_mshr_queue.sv
d1_wb_buffer.sv
d1_L2_req_arbiter.sv
d1_l2_req_issue.sv
d1_miss_subsys.sv
tb_d1_miss_subsys.sv
